// File: source/cachePkg.sv
// Shared cache geometry and controller states; widths assume one 64-bit block per line.
`default_nettype none

package cachePkg;

  ////////////////////////////////////////
  // Address and data widths.
  ////////////////////////////////////////

  // Processor and memory address width.
  localparam int AddrWidth = 16;
  // One processor data word.
  localparam int WordWidth = 16;
  // One cache block, also the memory data width.
  localparam int BlockWidth = 64;

  ////////////////////////////////////////
  // Address split.
  ////////////////////////////////////////

  // Tag bits kept per line.
  localparam int TagWidth = 8;
  // Index bits, giving 32 lines.
  localparam int IndexWidth = 5;
  // Word select inside the block.
  localparam int WordSelWidth = 2;

  ////////////////////////////////////////
  // Controller states.
  ////////////////////////////////////////

  // Fixed two-bit encoding.
  // 00 idle, 01 fill (read miss), 10 evict (write-back).
  typedef enum logic [1:0] {
    StIdle  = 2'b00,
    StFill  = 2'b01,
    StEvict = 2'b10
  } CtrlState;

endpackage

`default_nettype wire

// File: source/cacheStore.sv
// Direct-mapped line storage; reads are combinational, only valid and dirty bits are reset.
`timescale 1ns/1ps
`default_nettype none

module cacheStore (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cachePkg::IndexWidth-1:0]  index,
  input  logic [cachePkg::TagWidth-1:0]    inTag,
  input  logic [cachePkg::BlockWidth-1:0]  inBlock,
  input  logic                             inDirty,
  input  logic                             wr,
  output logic [cachePkg::TagWidth-1:0]    outTag,
  output logic [cachePkg::BlockWidth-1:0]  outBlock,
  output logic                             outValid,
  output logic                             outDirty
);

  // Number of lines in the cache.
  localparam int LineCount = 1 << cachePkg::IndexWidth;

  ////////////////////////////////////////
  // Storage arrays.
  ////////////////////////////////////////

  // Tag and block payload per line.
  logic [cachePkg::TagWidth-1:0]   tagMem   [LineCount];
  logic [cachePkg::BlockWidth-1:0] blockMem [LineCount];

  // Status bits per line, one bit per entry.
  logic [LineCount-1:0] validBits;
  logic [LineCount-1:0] dirtyBits;

  ////////////////////////////////////////
  // Write side.
  ////////////////////////////////////////

  // Payload write.
  // Tag and block are only meaningful once valid is set.
  always_ff @(posedge clk) begin
    if (wr) begin
      tagMem[index]   <= inTag;
      blockMem[index] <= inBlock;
    end
  end

  // Status write.
  // Reset empties the whole cache in one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (wr) begin
      // Any write makes the line valid.
      validBits[index] <= 1'b1;
      // Dirty follows the request type (store sets it, fill by load clears it).
      dirtyBits[index] <= inDirty;
    end
  end

  ////////////////////////////////////////
  // Read side.
  ////////////////////////////////////////

  // Lookup by index in the same cycle.
  assign outTag   = tagMem[index];
  assign outBlock = blockMem[index];
  assign outValid = validBits[index];
  assign outDirty = dirtyBits[index];

endmodule

`default_nettype wire

// File: source/cacheControl.sv
// Miss handling FSM; assumes one request at a time and a memory that never refuses mEn.
`timescale 1ns/1ps
`default_nettype none

module cacheControl (
  input  logic clk,
  input  logic reset,
  input  logic pEn,
  input  logic cacheHit,
  input  logic cacheEvict,
  input  logic done,
  output logic doStall,
  output logic fillSelect,
  output logic evictSelect,
  output logic mEn
);

  // Current and next controller state.
  cachePkg::CtrlState state;
  cachePkg::CtrlState stateNext;

  ////////////////////////////////////////
  // State register.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cachePkg::StIdle;
    end else begin
      state <= stateNext;
    end
  end

  ////////////////////////////////////////
  // Next state and outputs.
  ////////////////////////////////////////

  always_comb begin
    // Defaults hold the state and keep the bus quiet.
    stateNext   = state;
    doStall     = 1'b0;
    fillSelect  = 1'b0;
    evictSelect = 1'b0;
    mEn         = 1'b0;

    case (state)
      cachePkg::StIdle: begin
        // Hits complete here with no stall.
        // A miss stalls and sends its first memory request at once.
        if (pEn && !cacheHit) begin
          doStall = 1'b1;
          mEn     = 1'b1;
          if (cacheEvict) begin
            // Dirty victim goes out first, addressed by its own tag.
            evictSelect = 1'b1;
            stateNext   = cachePkg::StEvict;
          end else begin
            stateNext = cachePkg::StFill;
          end
        end
      end

      cachePkg::StEvict: begin
        // Wait for the write-back to finish.
        doStall = 1'b1;
        if (done) begin
          // Write-back is acknowledged, so the block read goes out now.
          mEn       = 1'b1;
          stateNext = cachePkg::StFill;
        end
      end

      cachePkg::StFill: begin
        // Stall until the block arrives.
        doStall = !done;
        if (done) begin
          // Memory block is used and written into the line this cycle.
          fillSelect = 1'b1;
          stateNext  = cachePkg::StIdle;
        end
      end

      default: begin
        // Unused encoding.
        stateNext = cachePkg::StIdle;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/cacheSystem.sv
// Cache datapath; full 16-bit word writes only, the byte address bit is ignored.
`timescale 1ns/1ps
`default_nettype none

module cacheSystem (
  input  logic                             clk,
  input  logic                             reset,
  // Processor side.
  input  logic                             pEn,
  input  logic                             pIsRd,
  input  logic [cachePkg::AddrWidth-1:0]   pAddr,
  input  logic [cachePkg::WordWidth-1:0]   pData,
  output logic                             doStall,
  output logic [cachePkg::WordWidth-1:0]   pResult,
  // Memory side.
  input  logic                             done,
  input  logic [cachePkg::BlockWidth-1:0]  mResult,
  output logic                             mEn,
  output logic                             mIsRd,
  output logic [cachePkg::AddrWidth-1:0]   mAddr,
  output logic [cachePkg::BlockWidth-1:0]  mData
);

  // Bit positions of the address fields.
  localparam int WordSelLsb = 1;
  localparam int IndexLsb   = WordSelLsb + cachePkg::WordSelWidth;
  localparam int TagLsb     = IndexLsb + cachePkg::IndexWidth;

  // Address fields of the current request.
  logic [cachePkg::TagWidth-1:0]     reqTag;
  logic [cachePkg::IndexWidth-1:0]   reqIndex;
  logic [cachePkg::WordSelWidth-1:0] reqWordSel;

  // Line lookup results.
  logic [cachePkg::TagWidth-1:0]   outTag;
  logic [cachePkg::BlockWidth-1:0] cacheBlock;
  logic                            outValid;
  logic                            outDirty;

  // Controls.
  logic cacheHit;
  logic cacheEvict;
  logic fillSelect;
  logic evictSelect;
  logic lineWr;

  // Block paths.
  logic [cachePkg::BlockWidth-1:0] resultBlock;
  logic [cachePkg::BlockWidth-1:0] writeBlock;

  assign reqTag     = pAddr[TagLsb +: cachePkg::TagWidth];
  assign reqIndex   = pAddr[IndexLsb +: cachePkg::IndexWidth];
  assign reqWordSel = pAddr[WordSelLsb +: cachePkg::WordSelWidth];

  ////////////////////////////////////////
  // Lookup and hit detection.
  ////////////////////////////////////////

  cacheStore storeUnit (
    .clk      (clk),
    .reset    (reset),
    .index    (reqIndex),
    .inTag    (reqTag),
    .inBlock  (writeBlock),
    .inDirty  (!pIsRd),
    .wr       (lineWr),
    .outTag   (outTag),
    .outBlock (cacheBlock),
    .outValid (outValid),
    .outDirty (outDirty)
  );

  // Hit needs a valid line with a matching tag.
  assign cacheHit   = outValid && (outTag == reqTag);
  // Miss on a valid dirty line must write the victim back.
  assign cacheEvict = !cacheHit && outValid && outDirty;

  cacheControl controlUnit (
    .clk         (clk),
    .reset       (reset),
    .pEn         (pEn),
    .cacheHit    (cacheHit),
    .cacheEvict  (cacheEvict),
    .done        (done),
    .doStall     (doStall),
    .fillSelect  (fillSelect),
    .evictSelect (evictSelect),
    .mEn         (mEn)
  );

  ////////////////////////////////////////
  // Block merge and result select.
  ////////////////////////////////////////

  // Fill cycle takes the memory block, otherwise the stored one.
  assign resultBlock = fillSelect ? mResult : cacheBlock;

  // Store replaces the addressed word; other words pass through.
  always_comb begin
    writeBlock = resultBlock;
    if (!pIsRd) begin
      writeBlock[reqWordSel*cachePkg::WordWidth +: cachePkg::WordWidth] = pData;
    end
  end

  // Line is written on a store hit or when a fill lands.
  assign lineWr = (pEn && cacheHit && !pIsRd) || fillSelect;

  // Read data comes from the chosen block, so fills return in the same cycle.
  assign pResult = resultBlock[reqWordSel*cachePkg::WordWidth +: cachePkg::WordWidth];

  ////////////////////////////////////////
  // Memory request fields.
  ////////////////////////////////////////

  // Victim address on write-back, request address on fetch.
  assign mAddr = {(evictSelect ? outTag : reqTag), reqIndex, IndexLsb'(0)};
  // Only the victim block is ever written out.
  assign mData = cacheBlock;
  assign mIsRd = !evictSelect;

endmodule

`default_nettype wire

// File: source/mainMemory.sv
// Simulation memory model; one operation in flight, MemLatency must be 1 or more.
`timescale 1ns/1ps
`default_nettype none

module mainMemory #(
  parameter int MemLatency = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             mEn,
  input  logic                             mIsRd,
  input  logic [cachePkg::AddrWidth-1:0]   mAddr,
  input  logic [cachePkg::BlockWidth-1:0]  mData,
  output logic                             done,
  output logic [cachePkg::BlockWidth-1:0]  mResult
);

  // Low address bits below the block boundary.
  localparam int OffsetWidth    = cachePkg::WordSelWidth + 1;
  // Block address bits, 13 for 8192 blocks.
  localparam int BlockAddrWidth = cachePkg::AddrWidth - OffsetWidth;
  localparam int BlockCount     = 1 << BlockAddrWidth;
  // Counter holds MemLatency-1 at most.
  localparam int CountWidth     = (MemLatency > 1) ? $clog2(MemLatency) : 1;

  // Backing store.
  logic [cachePkg::BlockWidth-1:0] memArray [BlockCount];

  // Block address of the request.
  logic [BlockAddrWidth-1:0] blockAddr;
  // Cycles left before done.
  logic [CountWidth-1:0]     count;
  logic                      doneNext;

  assign blockAddr = mAddr[OffsetWidth +: BlockAddrWidth];

  // Memory starts out all zero.
  initial begin
    for (int i = 0; i < BlockCount; i++) begin
      memArray[i] = '0;
    end
  end

  ////////////////////////////////////////
  // Array access.
  ////////////////////////////////////////

  // Writes land in the request cycle, reads are captured then too.
  always_ff @(posedge clk) begin
    if (mEn && !mIsRd) begin
      memArray[blockAddr] <= mData;
    end
    if (mEn && mIsRd) begin
      mResult <= memArray[blockAddr];
    end
  end

  ////////////////////////////////////////
  // Latency counter.
  ////////////////////////////////////////

  // done is registered, so it rises one cycle after count reaches 1.
  assign doneNext = (MemLatency == 1) ? mEn : (count == CountWidth'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= doneNext;
      if (mEn) begin
        count <= CountWidth'(MemLatency - 1);
      end else if (count != '0) begin
        count <= count - CountWidth'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/memorySubsystem.sv
// Cache plus backing memory; MemLatency sets the miss penalty and must be 1 or more.
`timescale 1ns/1ps
`default_nettype none

module memorySubsystem #(
  parameter int MemLatency = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  // Processor request.
  input  logic                            pEn,
  input  logic                            pIsRd,
  input  logic [cachePkg::AddrWidth-1:0]  pAddr,
  input  logic [cachePkg::WordWidth-1:0]  pData,
  // Processor reply.
  output logic                            doStall,
  output logic [cachePkg::WordWidth-1:0]  pResult
);

  ////////////////////////////////////////
  // Cache to memory bus.
  ////////////////////////////////////////

  logic                            mEn;
  logic                            mIsRd;
  logic [cachePkg::AddrWidth-1:0]  mAddr;
  logic [cachePkg::BlockWidth-1:0] mData;
  logic                            done;
  logic [cachePkg::BlockWidth-1:0] mResult;

  // Cache controller and datapath.
  cacheSystem cacheUnit (
    .clk     (clk),
    .reset   (reset),
    .pEn     (pEn),
    .pIsRd   (pIsRd),
    .pAddr   (pAddr),
    .pData   (pData),
    .doStall (doStall),
    .pResult (pResult),
    .done    (done),
    .mResult (mResult),
    .mEn     (mEn),
    .mIsRd   (mIsRd),
    .mAddr   (mAddr),
    .mData   (mData)
  );

  // Backing store with fixed latency.
  mainMemory #(
    .MemLatency (MemLatency)
  ) memoryUnit (
    .clk     (clk),
    .reset   (reset),
    .mEn     (mEn),
    .mIsRd   (mIsRd),
    .mAddr   (mAddr),
    .mData   (mData),
    .done    (done),
    .mResult (mResult)
  );

endmodule

`default_nettype wire

// File: test/memorySubsystemTb.sv
// Random cache testbench; one request at a time, LFSR seed fixed, MemLatency 4 assumed below.
`timescale 1ns/1ps
`default_nettype none

module memorySubsystemTb;

  localparam int MemLatency    = 4;
  localparam int ClkPeriod     = 20;
  localparam int RequestCount  = 400;
  // Longest legal wait is a dirty miss, with some margin.
  localparam int TimeoutCycles = 4 * MemLatency + 16;
  localparam int LineCount     = 1 << cachePkg::IndexWidth;
  localparam int ModelWords    = 1 << (cachePkg::AddrWidth - 1);
  // Field positions above the ignored byte bit.
  localparam int IndexLsb      = 1 + cachePkg::WordSelWidth;
  localparam int TagLsb        = IndexLsb + cachePkg::IndexWidth;
  localparam logic [15:0] LfsrSeed = 16'd14394;

  logic                           clk;
  logic                           reset;
  logic                           pEn;
  logic                           pIsRd;
  logic [cachePkg::AddrWidth-1:0] pAddr;
  logic [cachePkg::WordWidth-1:0] pData;
  logic                           doStall;
  logic [cachePkg::WordWidth-1:0] pResult;

  // Word model of memory, indexed by the address without the byte bit.
  logic [cachePkg::WordWidth-1:0] modelMem [ModelWords];
  // Shadow of the line status, to predict the latency.
  logic [cachePkg::TagWidth-1:0]  shadowTag   [LineCount];
  logic                           shadowValid [LineCount];
  logic                           shadowDirty [LineCount];
  // Small tag set so lines conflict often.
  logic [cachePkg::TagWidth-1:0]  tagSet [4];
  logic [15:0]                    lfsrState;
  // Outcome counters for the summary.
  int hitCount;
  int cleanCount;
  int dirtyCount;

  memorySubsystem #(
    .MemLatency (MemLatency)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .pEn     (pEn),
    .pIsRd   (pIsRd),
    .pAddr   (pAddr),
    .pData   (pData),
    .doStall (doStall),
    .pResult (pResult)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Random source and failure handling.
  ////////////////////////////////////////

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic feedback;
    feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], feedback};
  endfunction

  // One LFSR step per bit.
  task automatic randomBits(input int count, output logic [15:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value     = {value[14:0], lfsrState[0]};
    end
  endtask

  task automatic stopOnFailure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after the first failure.");
  endtask

  task automatic checkWord(input logic [cachePkg::WordWidth-1:0] actual,
                           input logic [cachePkg::WordWidth-1:0] expected,
                           input string what);
    if (actual !== expected) begin
      stopOnFailure($sformatf("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                              $time, what, actual, expected));
    end
  endtask

  task automatic checkLatency(input int actual, input int expected, input string what);
    if (actual != expected) begin
      stopOnFailure($sformatf("CHECK FAILED at %0d ns: %s, took %0d cycles, expected %0d",
                              $time, what, actual, expected));
    end
  endtask

  task automatic checkState(input cachePkg::CtrlState actual,
                            input cachePkg::CtrlState expected, input string what);
    if (actual !== expected) begin
      stopOnFailure($sformatf("CHECK FAILED at %0d ns: %s, got %s, expected %s",
                              $time, what, actual.name(), expected.name()));
    end
  endtask

  ////////////////////////////////////////
  // One processor request.
  ////////////////////////////////////////

  // Called at a falling edge; returns at the falling edge after completion.
  task automatic runRequest(input logic isRd, input logic [15:0] addr, input logic [15:0] data);
    logic [cachePkg::IndexWidth-1:0] lineIndex;
    logic [cachePkg::TagWidth-1:0]   lineTag;
    logic                            isHit;
    logic                            completed;
    int                              expectedLatency;
    int                              cycles;
    lineIndex = addr[IndexLsb +: cachePkg::IndexWidth];
    lineTag   = addr[TagLsb +: cachePkg::TagWidth];
    isHit     = shadowValid[lineIndex] && (shadowTag[lineIndex] == lineTag);
    // Hit in cycle 0, clean miss after one memory trip, dirty miss after two.
    if (isHit) begin
      expectedLatency = 0;
      hitCount++;
    end else if (shadowValid[lineIndex] && shadowDirty[lineIndex]) begin
      expectedLatency = 2 * MemLatency;
      dirtyCount++;
    end else begin
      expectedLatency = MemLatency;
      cleanCount++;
    end
    pEn   = 1'b1;
    pIsRd = isRd;
    pAddr = addr;
    pData = data;
    cycles    = 0;
    completed = 1'b0;
    // Sample a quarter period after the drive, well before the rising edge.
    while (!completed) begin
      #(ClkPeriod / 4);
      if (!doStall) begin
        completed = 1'b1;
      end else if (cycles >= TimeoutCycles) begin
        stopOnFailure($sformatf("Request to address %h never completed, stall stayed high.",
                                addr));
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    checkLatency(cycles, expectedLatency,
                 $sformatf("%s at %h", isRd ? "read" : "write", addr));
    if (isRd) begin
      checkWord(pResult, modelMem[addr[15:1]], $sformatf("read data at %h", addr));
    end else begin
      modelMem[addr[15:1]] = data;
    end
    // Line status after the access.
    if (isHit) begin
      shadowDirty[lineIndex] = shadowDirty[lineIndex] || !isRd;
    end else begin
      shadowTag[lineIndex]   = lineTag;
      shadowValid[lineIndex] = 1'b1;
      shadowDirty[lineIndex] = !isRd;
    end
    @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Main sequence.
  ////////////////////////////////////////

  initial begin
    logic [15:0]                    bits;
    logic                           isRd;
    logic [1:0]                     tagSel;
    logic [cachePkg::AddrWidth-1:0] addr;
    logic [cachePkg::WordWidth-1:0] data;
    int                             n;
    int                             i;
    reset = 1'b1;
    pEn   = 1'b0;
    pIsRd = 1'b1;
    pAddr = '0;
    pData = '0;
    lfsrState  = LfsrSeed;
    hitCount   = 0;
    cleanCount = 0;
    dirtyCount = 0;
    tagSet[0]  = 8'h00;
    tagSet[1]  = 8'h3c;
    tagSet[2]  = 8'ha5;
    tagSet[3]  = 8'hf1;
    // Memory starts at zero, so does the model.
    for (i = 0; i < ModelWords; i++) begin
      modelMem[i] = '0;
    end
    for (i = 0; i < LineCount; i++) begin
      shadowTag[i]   = '0;
      shadowValid[i] = 1'b0;
      shadowDirty[i] = 1'b0;
    end

    // Five rising edges with reset high.
    repeat (5) @(negedge clk);
    reset = 1'b0;
    checkState(dut_i.cacheUnit.controlUnit.state, cachePkg::StIdle,
               "controller state after reset");

    for (n = 0; n < RequestCount; n++) begin
      randomBits(1, bits);
      isRd = bits[0];
      randomBits(2, bits);
      tagSel = bits[1:0];
      // Index, word select and the ignored byte bit.
      randomBits(8, bits);
      addr = {tagSet[tagSel], bits[7:0]};
      randomBits(16, bits);
      data = bits;
      // Now and then an idle cycle between requests.
      randomBits(3, bits);
      if (bits[2:0] == 3'd0) begin
        pEn = 1'b0;
        @(negedge clk);
      end
      runRequest(isRd, addr, data);
    end
    pEn = 1'b0;

    $display("Requests: %0d hits, %0d clean misses, %0d dirty misses.",
             hitCount, cleanCount, dirtyCount);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/cachePkg.sv
source/cacheStore.sv
source/cacheControl.sv
source/cacheSystem.sv
source/mainMemory.sv
source/memorySubsystem.sv
test/memorySubsystemTb.sv

// File: run.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module memorySubsystemTb -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit 1
fi

output=$(./obj_dir/VmemorySubsystemTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

# The run passes only if the testbench printed its pass line.
if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  echo "Pass line not found in the simulation output."
  exit 1
fi
